// File: hdl/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path and address width
`define EXU_XLEN 32

// global history bits carried with each prediction
`define EXU_HISLEN 8

`define EXU_REG_AW 5    // rd index width

// trap bits that ride along the pipe, decoded later
`define EXU_TRAP_LEN 4

// opaque micro-op fields owned by the memory and pc stages
`define EXU_MEMOP_LEN 4
`define EXU_PCOP_LEN 2

`endif

// File: hdl/exu_isa_pkg.sv
package exu_isa_pkg;

  // execute opcode from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_LOAD   = 4'd5,
    EXC_STORE  = 4'd6,
    EXC_BRANCH = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9,
    EXC_EBREAK = 4'd10
  } exc_op_e;

  // alu operation, the B* codes only drive the compare output
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_BEQ  = 4'd10,
    ALU_BNE  = 4'd11,
    ALU_BLT  = 4'd12,
    ALU_BGE  = 4'd13,
    ALU_BLTU = 4'd14,
    ALU_BGEU = 4'd15
  } alu_op_e;

  // jump class reported to fetch
  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

endpackage

// File: hdl/exu_pipe_pkg.sv
`include "exu_params.svh"

package exu_pipe_pkg;

  // one issued instruction, decode -> execute
  typedef struct packed {
    logic [`EXU_XLEN-1:0]      inst_addr;
    logic [`EXU_XLEN-1:0]      inst_data;
    logic [`EXU_REG_AW-1:0]    rd_idx;
    logic [`EXU_XLEN-1:0]      rs1_data;
    logic [`EXU_XLEN-1:0]      rs2_data;
    logic [`EXU_XLEN-1:0]      imm;
    exu_isa_pkg::alu_op_e      alu_op;
    logic [`EXU_MEMOP_LEN-1:0] mem_op;
    exu_isa_pkg::exc_op_e      exc_op;
    logic [`EXU_PCOP_LEN-1:0]  pc_op;
    logic [`EXU_TRAP_LEN-1:0]  trap;
    logic                      valid;
  } idex_t;

  // predictor guess attached at fetch
  typedef struct packed {
    logic                   taken;
    logic                   which_pdt;   // selector of the predictor used
    logic [`EXU_HISLEN-1:0] history;
    logic [`EXU_XLEN-1:0]   tag;         // pc the guess was made for
  } pdt_info_t;

  // execute -> memory
  typedef struct packed {
    logic [`EXU_XLEN-1:0]      inst_addr;
    logic [`EXU_XLEN-1:0]      inst_data;
    logic [`EXU_REG_AW-1:0]    rd_idx;
    logic [`EXU_XLEN-1:0]      rs1_data;
    logic [`EXU_XLEN-1:0]      rs2_data;
    logic [`EXU_XLEN-1:0]      imm;
    logic [`EXU_MEMOP_LEN-1:0] mem_op;
    exu_isa_pkg::exc_op_e      exc_op;
    logic [`EXU_PCOP_LEN-1:0]  pc_op;
    logic [`EXU_TRAP_LEN-1:0]  trap;
    logic [`EXU_XLEN-1:0]      alu_data;
    logic                      valid;
  } exmem_t;

  // feedback to the predictor tables
  typedef struct packed {
    logic                    valid;
    logic                    taken;
    logic                    correct;
    logic                    which_pdt;
    logic [`EXU_HISLEN-1:0]  history;
    logic [`EXU_XLEN-1:0]    pc;
    exu_isa_pkg::jump_type_e jump_type;
    logic [`EXU_REG_AW-1:0]  rd_idx;   // lets fetch spot calls and returns
  } bpu_update_t;

  typedef struct packed {
    logic                 valid;
    logic [`EXU_XLEN-1:0] pc;
  } redirect_t;

endpackage

// File: hdl/alu_top.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module alu_top (
  input  logic [`EXU_XLEN-1:0] alu_a_i,
  input  logic [`EXU_XLEN-1:0] alu_b_i,
  input  exu_isa_pkg::alu_op_e alu_op_i,
  output logic [`EXU_XLEN-1:0] alu_out_o,
  output logic                 compare_out_o
);

  localparam int SHAMT_W = $clog2(`EXU_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic               eq;

  assign shamt = alu_b_i[SHAMT_W-1:0];   // only low bits count for shifts
  assign lt_s  = $signed(alu_a_i) < $signed(alu_b_i);
  assign lt_u  = alu_a_i < alu_b_i;
  assign eq    = alu_a_i == alu_b_i;

  always_comb begin
    alu_out_o     = '0;
    compare_out_o = 1'b0;
    case (alu_op_i)
      exu_isa_pkg::ALU_ADD:  alu_out_o = alu_a_i + alu_b_i;
      exu_isa_pkg::ALU_SUB:  alu_out_o = alu_a_i - alu_b_i;
      exu_isa_pkg::ALU_SLL:  alu_out_o = alu_a_i << shamt;
      exu_isa_pkg::ALU_SLT:  alu_out_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      exu_isa_pkg::ALU_SLTU: alu_out_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      exu_isa_pkg::ALU_XOR:  alu_out_o = alu_a_i ^ alu_b_i;
      exu_isa_pkg::ALU_SRL:  alu_out_o = alu_a_i >> shamt;
      exu_isa_pkg::ALU_SRA:  alu_out_o = $unsigned($signed(alu_a_i) >>> shamt);
      exu_isa_pkg::ALU_OR:   alu_out_o = alu_a_i | alu_b_i;
      exu_isa_pkg::ALU_AND:  alu_out_o = alu_a_i & alu_b_i;
      // branch relations, result bus stays 0
      exu_isa_pkg::ALU_BEQ:  compare_out_o = eq;
      exu_isa_pkg::ALU_BNE:  compare_out_o = !eq;
      exu_isa_pkg::ALU_BLT:  compare_out_o = lt_s;
      exu_isa_pkg::ALU_BGE:  compare_out_o = !lt_s;
      exu_isa_pkg::ALU_BLTU: compare_out_o = lt_u;
      exu_isa_pkg::ALU_BGEU: compare_out_o = !lt_u;
      default: begin
        alu_out_o     = '0;
        compare_out_o = 1'b0;
      end
    endcase
  end

endmodule

// File: hdl/exu_branch_resolve.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_branch_resolve (
  input  exu_pipe_pkg::idex_t       instr_i,
  input  exu_pipe_pkg::pdt_info_t   pdt_i,
  input  logic                      compare_i,
  output exu_pipe_pkg::redirect_t   redirect_o,
  output exu_pipe_pkg::bpu_update_t bpu_update_o
);

  logic                 is_jal;
  logic                 is_jalr;
  logic                 is_branch;
  logic                 is_jump;
  logic                 taken;
  logic                 pdt_valid;
  logic [`EXU_XLEN-1:0] tgt_base;
  logic [`EXU_XLEN-1:0] tgt_offs;
  exu_isa_pkg::jump_type_e jump_type;

  assign is_jal    = instr_i.exc_op == exu_isa_pkg::EXC_JAL;
  assign is_jalr   = instr_i.exc_op == exu_isa_pkg::EXC_JALR;
  assign is_branch = instr_i.exc_op == exu_isa_pkg::EXC_BRANCH;
  assign is_jump   = is_jal | is_jalr | is_branch;

  assign taken     = is_jal | is_jalr | (is_branch & compare_i);
  // guess only counts if it was made for this very pc
  assign pdt_valid = pdt_i.taken & (pdt_i.tag == instr_i.inst_addr);

  always_comb begin
    if (pdt_i.taken && !taken) begin   // fell through, back to the next instr
      tgt_base = instr_i.inst_addr;
      tgt_offs = `EXU_XLEN'd4;
    end else begin
      tgt_base = is_jalr ? instr_i.rs1_data : instr_i.inst_addr;
      tgt_offs = instr_i.imm;
    end
  end

  always_comb begin
    case (instr_i.exc_op)
      exu_isa_pkg::EXC_JAL:    jump_type = exu_isa_pkg::JT_JAL;
      exu_isa_pkg::EXC_JALR:   jump_type = exu_isa_pkg::JT_JALR;
      exu_isa_pkg::EXC_BRANCH: jump_type = exu_isa_pkg::JT_BRANCH;
      default:                 jump_type = exu_isa_pkg::JT_NONE;
    endcase
  end

  assign redirect_o.valid = instr_i.valid & (taken != pdt_i.taken);
  assign redirect_o.pc    = tgt_base + tgt_offs;

  assign bpu_update_o.valid     = instr_i.valid & is_jump;
  assign bpu_update_o.taken     = taken;
  assign bpu_update_o.correct   = pdt_valid & (taken == pdt_i.taken);
  assign bpu_update_o.which_pdt = pdt_i.which_pdt;
  assign bpu_update_o.history   = pdt_i.history;
  assign bpu_update_o.pc        = instr_i.inst_addr;
  assign bpu_update_o.jump_type = jump_type;
  assign bpu_update_o.rd_idx    = instr_i.rd_idx;

endmodule

// File: hdl/exu.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu (
  input  exu_pipe_pkg::idex_t       instr_i,
  input  exu_pipe_pkg::pdt_info_t   pdt_i,
  output exu_pipe_pkg::exmem_t      result_o,
  output exu_pipe_pkg::redirect_t   redirect_o,
  output exu_pipe_pkg::bpu_update_t bpu_update_o
);

  logic [`EXU_XLEN-1:0] op_a;
  logic [`EXU_XLEN-1:0] op_b;
  logic [`EXU_XLEN-1:0] imm_upper;
  logic [`EXU_XLEN-1:0] alu_out;
  logic                 compare_out;

  assign imm_upper = {instr_i.imm[`EXU_XLEN-1:12], 12'b0};   // lui/auipc form

  // operand select by execute opcode
  always_comb begin
    op_a = '0;
    op_b = '0;
    case (instr_i.exc_op)
      exu_isa_pkg::EXC_OPREG, exu_isa_pkg::EXC_BRANCH: begin
        op_a = instr_i.rs1_data;
        op_b = instr_i.rs2_data;
      end
      exu_isa_pkg::EXC_OPIMM, exu_isa_pkg::EXC_LOAD, exu_isa_pkg::EXC_STORE: begin
        op_a = instr_i.rs1_data;
        op_b = instr_i.imm;   // address for load/store
      end
      exu_isa_pkg::EXC_JAL, exu_isa_pkg::EXC_JALR: begin
        op_a = instr_i.inst_addr;
        op_b = `EXU_XLEN'd4;   // link value
      end
      exu_isa_pkg::EXC_AUIPC: begin
        op_a = instr_i.inst_addr;
        op_b = imm_upper;
      end
      exu_isa_pkg::EXC_LUI: op_b = imm_upper;   // 0 + imm
      default: ;   // none, ebreak
    endcase
  end

  alu_top u_alu (
    .alu_a_i       (op_a),
    .alu_b_i       (op_b),
    .alu_op_i      (instr_i.alu_op),
    .alu_out_o     (alu_out),
    .compare_out_o (compare_out)
  );

  exu_branch_resolve u_branch_resolve (
    .instr_i      (instr_i),
    .pdt_i        (pdt_i),
    .compare_i    (compare_out),
    .redirect_o   (redirect_o),
    .bpu_update_o (bpu_update_o)
  );

  assign result_o.inst_addr = instr_i.inst_addr;
  assign result_o.inst_data = instr_i.inst_data;
  assign result_o.rd_idx    = instr_i.rd_idx;
  assign result_o.rs1_data  = instr_i.rs1_data;
  assign result_o.rs2_data  = instr_i.rs2_data;   // store data for mem
  assign result_o.imm       = instr_i.imm;
  assign result_o.mem_op    = instr_i.mem_op;
  assign result_o.exc_op    = instr_i.exc_op;
  assign result_o.pc_op     = instr_i.pc_op;
  assign result_o.trap      = instr_i.trap;
  assign result_o.alu_data  = alu_out;
  assign result_o.valid     = instr_i.valid;

endmodule

// File: hdl/exu_stage_top.sv
`timescale 1ns/1ps

module exu_stage_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  exu_pipe_pkg::idex_t       issue_i,
  input  exu_pipe_pkg::pdt_info_t   pdt_i,
  input  logic                      stall_i,
  output exu_pipe_pkg::exmem_t      exmem_o,
  output exu_pipe_pkg::redirect_t   redirect_o,
  output logic                      flush_o,
  output exu_pipe_pkg::bpu_update_t bpu_update_o
);

  exu_pipe_pkg::idex_t     idex_d;
  exu_pipe_pkg::idex_t     idex_q;
  exu_pipe_pkg::pdt_info_t pdt_q;
  exu_pipe_pkg::exmem_t    exu_result;
  exu_pipe_pkg::exmem_t    exmem_q;
  exu_pipe_pkg::redirect_t redirect;

  // younger instr is on the wrong path when ex redirects
  always_comb begin
    idex_d = issue_i;
    if (redirect.valid) begin
      idex_d.valid = 1'b0;
    end
  end

  // id/ex
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idex_q <= '0;
      pdt_q  <= '0;
    end else if (!stall_i) begin
      idex_q <= idex_d;
      pdt_q  <= pdt_i;
    end
  end

  exu u_exu (
    .instr_i      (idex_q),
    .pdt_i        (pdt_q),
    .result_o     (exu_result),
    .redirect_o   (redirect),
    .bpu_update_o (bpu_update_o)
  );

  // ex/mem, frozen together with id/ex on a memory stall
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exmem_q <= '0;
    end else if (!stall_i) begin
      exmem_q <= exu_result;
    end
  end

  assign exmem_o    = exmem_q;
  assign redirect_o = redirect;
  assign flush_o    = redirect.valid;   // kills if/id upstream

endmodule

// File: sim/exu_stage_tb.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_stage_tb;

  localparam int MAX_CASES = 64;

  // one line of the case file
  typedef struct packed {
    logic [3:0]           exc;
    logic [3:0]           alu;
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] rs1;
    logic [`EXU_XLEN-1:0] rs2;
    logic [`EXU_XLEN-1:0] imm;
    logic                 ptaken;
    logic [`EXU_XLEN-1:0] ptag;
    logic [1:0]           stall;
    logic [`EXU_XLEN-1:0] exp_alu;
    logic                 exp_redir;
    logic [`EXU_XLEN-1:0] exp_tgt;
    logic                 exp_taken;
    logic                 exp_correct;
    logic [1:0]           exp_jt;
  } tcase_t;

  logic                      clk_i;
  logic                      rst_n_i;
  exu_pipe_pkg::idex_t       issue_i;
  exu_pipe_pkg::pdt_info_t   pdt_i;
  logic                      stall_i;
  exu_pipe_pkg::exmem_t      exmem_o;
  exu_pipe_pkg::redirect_t   redirect_o;
  logic                      flush_o;
  exu_pipe_pkg::bpu_update_t bpu_update_o;

  tcase_t      cases [MAX_CASES];
  string       case_name [MAX_CASES];
  string       cur_name = "reset";
  int          n_cases = 0;
  int          checks = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  logic [31:0] lfsr_state = 32'he8dd1c16;

  exu_stage_top uut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue_i      (issue_i),
    .pdt_i        (pdt_i),
    .stall_i      (stall_i),
    .exmem_o      (exmem_o),
    .redirect_o   (redirect_o),
    .flush_o      (flush_o),
    .bpu_update_o (bpu_update_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // galois lfsr stepped once per bit taken
  function automatic int unsigned next_rand_bits(int n);
    int unsigned v;
    int          k;
    v = 0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       nm;
    logic [31:0] col [15];
    fd = $fopen("sim/exu_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file sim/exu_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or column notes
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                  col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
      if (n != 16) begin
        $display("malformed line in the case file: %s", line);
        errors++;
      end else begin
        case_name[n_cases] = nm;
        cases[n_cases] = '{col[0][3:0], col[1][3:0], col[2], col[3], col[4], col[5],
                           col[6][0], col[7], col[8][1:0], col[9], col[10][0], col[11],
                           col[12][0], col[13][0], col[14][1:0]};
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  function automatic exu_pipe_pkg::idex_t make_instr(tcase_t c, int i);
    exu_pipe_pkg::idex_t t;
    t = '0;
    t.inst_addr = c.addr;
    t.inst_data = {c.exc, c.alu, i[23:0]};   // just a marker
    t.rd_idx    = i[4:0];
    t.rs1_data  = c.rs1;
    t.rs2_data  = c.rs2;
    t.imm       = c.imm;
    t.alu_op    = exu_isa_pkg::alu_op_e'(c.alu);
    t.mem_op    = i[4:1];
    t.exc_op    = exu_isa_pkg::exc_op_e'(c.exc);
    t.pc_op     = i[2:1];
    t.trap      = i[3:0];
    t.valid     = 1'b1;
    return t;
  endfunction

  // younger instr fetched down the wrong path
  function automatic exu_pipe_pkg::idex_t wrong_path_instr();
    exu_pipe_pkg::idex_t t;
    t = '0;
    t.inst_addr = 32'hdead0000;
    t.exc_op    = exu_isa_pkg::EXC_OPREG;
    t.valid     = 1'b1;
    return t;
  endfunction

  task automatic run_case(int i);
    tcase_t               c;
    logic                 wrong_path;
    logic                 upd_exp;
    int                   s;
    exu_pipe_pkg::exmem_t held;
    c = cases[i];
    cur_name = case_name[i];
    wrong_path = c.exp_redir && (c.stall == 0);
    upd_exp = (c.exc == 4'd3) || (c.exc == 4'd4) || (c.exc == 4'd7);
    @(posedge clk_i);
    issue_i <= make_instr(c, i);
    pdt_i   <= '{taken: c.ptaken, which_pdt: i[0], history: i[7:0], tag: c.ptag};
    stall_i <= 1'b0;
    @(posedge clk_i);   // now in id/ex
    issue_i <= wrong_path ? wrong_path_instr() : '0;
    pdt_i   <= '0;
    stall_i <= (c.stall != 0);
    @(negedge clk_i);
    check_val("redirect valid", c.exp_redir, redirect_o.valid);
    check_val("flush", c.exp_redir, flush_o);
    if (c.exp_redir) check_val("redirect pc", c.exp_tgt, redirect_o.pc);
    check_val("update valid", upd_exp, bpu_update_o.valid);
    if (upd_exp) begin
      check_val("update taken", c.exp_taken, bpu_update_o.taken);
      check_val("update correct", c.exp_correct, bpu_update_o.correct);
      check_val("update jump type", c.exp_jt, bpu_update_o.jump_type);
      check_val("update pc", c.addr, bpu_update_o.pc);
      check_val("update selector", i[0], bpu_update_o.which_pdt);
      check_val("update history", i[7:0], bpu_update_o.history);
      check_val("update rd", i[4:0], bpu_update_o.rd_idx);
    end
    held = exmem_o;
    for (s = 0; s < c.stall; s++) begin
      @(posedge clk_i);
      issue_i <= '0;
      if (s == c.stall - 1) stall_i <= 1'b0;
      @(negedge clk_i);
      checks++;
      assert (exmem_o === held) else begin
        $display("exmem_o changed while stall was high in case %s", cur_name);
        errors++;
      end
    end
    @(posedge clk_i);   // ex/mem load
    issue_i <= '0;
    @(negedge clk_i);
    check_val("exmem valid", 1, exmem_o.valid);
    check_val("exmem alu", c.exp_alu, exmem_o.alu_data);
    check_val("exmem addr", c.addr, exmem_o.inst_addr);
    check_val("exmem data", {c.exc, c.alu, i[23:0]}, exmem_o.inst_data);
    check_val("exmem rd", i[4:0], exmem_o.rd_idx);
    check_val("exmem rs1", c.rs1, exmem_o.rs1_data);
    check_val("exmem rs2", c.rs2, exmem_o.rs2_data);
    check_val("exmem imm", c.imm, exmem_o.imm);
    check_val("exmem mem op", i[4:1], exmem_o.mem_op);
    check_val("exmem exc op", c.exc, exmem_o.exc_op);
    check_val("exmem pc op", i[2:1], exmem_o.pc_op);
    check_val("exmem trap", i[3:0], exmem_o.trap);
    if (wrong_path) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_val("wrong path valid", 0, exmem_o.valid);   // must be the bubble
    end
    repeat (next_rand_bits(2)) @(posedge clk_i);
  endtask

  initial begin
    issue_i = '0;
    pdt_i   = '0;
    stall_i = 1'b0;
    rst_n_i = 1'b0;
    load_cases();
    cycle_limit = 12 * n_cases + 10 + 4;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("exmem valid", 0, exmem_o.valid);
    check_val("redirect valid", 0, redirect_o.valid);
    check_val("flush", 0, flush_o);
    check_val("update valid", 0, bpu_update_o.valid);
    for (int i = 0; i < n_cases; i++) run_case(i);
    repeat (2) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // run limit scales with the number of cases
  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: exu_stage_top.f
+incdir+hdl
hdl/exu_isa_pkg.sv
hdl/exu_pipe_pkg.sv
hdl/alu_top.sv
hdl/exu_branch_resolve.sv
hdl/exu.sv
hdl/exu_stage_top.sv
sim/exu_stage_tb.sv

// File: Bender.yml
package:
  name: exu_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exu_isa_pkg.sv
      - hdl/exu_pipe_pkg.sv
      - hdl/alu_top.sv
      - hdl/exu_branch_resolve.sv
      - hdl/exu.sv
      - hdl/exu_stage_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/exu_stage_tb.sv

// File: sim/exu_cases.txt
# name exc alu addr rs1 rs2 imm pdt_taken pdt_tag stall | exp: alu redir target taken correct jt
# hex fields; exc 9=opreg 8=opimm 7=branch 4=jalr 3=jal; jt 1=jal 2=jalr 3=branch
add_reg    9 0 00001000 00000005 00000007 00000000 0 00000000 0 0000000c 0 00000000 0 0 0
sub_reg    9 1 00001004 00000003 00000005 00000000 0 00000000 0 fffffffe 0 00000000 0 0 0
sll_imm    8 2 00001008 00000001 00000000 0000001f 0 00000000 2 80000000 0 00000000 0 0 0
slt_neg    9 3 0000100c ffffffff 00000001 00000000 0 00000000 0 00000001 0 00000000 0 0 0
sltu_neg   9 4 00001010 ffffffff 00000001 00000000 0 00000000 0 00000000 0 00000000 0 0 0
xor_imm    8 5 00001014 0f0f0f0f 00000000 ffffffff 0 00000000 0 f0f0f0f0 0 00000000 0 0 0
srl_reg    9 6 00001018 80000000 00000004 00000000 0 00000000 0 08000000 0 00000000 0 0 0
sra_neg    9 7 0000101c 80000000 00000004 00000000 0 00000000 1 f8000000 0 00000000 0 0 0
or_imm     8 8 00001020 00f000f0 00000000 0000000f 0 00000000 0 00f000ff 0 00000000 0 0 0
and_reg    9 9 00001024 ff00ff00 0ff00ff0 00000000 0 00000000 0 0f000f00 0 00000000 0 0 0
sra_shamt  9 7 00001028 fffffff0 00000021 00000000 0 00000000 0 fffffff8 0 00000000 0 0 0
load_addr  5 0 0000102c 00002000 00000000 fffffffc 0 00000000 0 00001ffc 0 00000000 0 0 0
lui        1 0 00001030 00000000 00000000 12345678 0 00000000 0 12345000 0 00000000 0 0 0
auipc      2 0 00001034 00000000 00000000 00002abc 0 00000000 0 00003034 0 00000000 0 0 0
jal_miss   3 0 00001038 00000000 00000000 00000100 0 00000000 0 0000103c 1 00001138 1 0 1
jal_hit    3 0 00001100 00000000 00000000 00000040 1 00001100 3 00001104 0 00000000 1 1 1
jalr_miss  4 0 00001200 00004000 00000000 00000010 0 00000000 0 00001204 1 00004010 1 0 2
beq_taken  7 a 00001300 00000005 00000005 00000020 0 00000000 0 00000000 1 00001320 1 0 3
beq_not    7 a 00001304 00000005 00000006 00000020 0 00000000 0 00000000 0 00000000 0 0 3
bne_taken  7 b 00001308 00000005 00000006 fffffff0 0 00000000 0 00000000 1 000012f8 1 0 3
blt_taken  7 c 0000130c ffffffff 00000001 00000008 0 00000000 0 00000000 1 00001314 1 0 3
bge_not    7 d 00001310 ffffffff 00000001 00000008 0 00000000 0 00000000 0 00000000 0 0 3
bltu_not   7 e 00001314 ffffffff 00000001 00000008 0 00000000 0 00000000 0 00000000 0 0 3
bgeu_taken 7 f 00001318 ffffffff 00000001 00000040 0 00000000 2 00000000 1 00001358 1 0 3
pdt_fall   7 a 00001400 00000001 00000002 00000080 1 00001400 0 00000000 1 00001404 0 0 3
pdt_hit    7 a 00001404 00000002 00000002 00000080 1 00001404 0 00000000 0 00000000 1 1 3
pdt_tagmis 7 a 00001408 00000002 00000002 00000080 1 00001500 0 00000000 0 00000000 1 0 3
jalr_stall 4 0 00001500 00008001 00000000 fffffff0 0 00000000 1 00001504 1 00007ff1 1 0 2
ebreak     a 0 00001504 00000000 00000000 00000000 0 00000000 0 00000000 0 00000000 0 0 0
store_addr 6 0 00001508 00003000 00000000 00000008 0 00000000 0 00003008 0 00000000 0 0 0
